// ==== alu_station.sv ====
module alu_station (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               accept,
    input  cpu_pkg::dispatch_t dispatch,
    output cpu_pkg::result_t   result,
    output logic               full
);

    // entries stay packed from slot 0, so slot 0 is the oldest
    cpu_pkg::dispatch_t ent [cpu_pkg::RS_DEPTH];
    cpu_pkg::dispatch_t wk  [cpu_pkg::RS_DEPTH + 1];
    cpu_pkg::dispatch_t nxt [cpu_pkg::RS_DEPTH];

    logic                         issue_hit;
    logic [cpu_pkg::RS_IDX_W-1:0] issue_idx;
    logic                         placed;

    function automatic logic [cpu_pkg::XLEN-1:0] alu_calc(
        input cpu_pkg::alu_op_e         op,
        input logic [cpu_pkg::XLEN-1:0] a,
        input logic [cpu_pkg::XLEN-1:0] b
    );
        logic [4:0] shamt;
        shamt = b[4:0];
        case (op)
            cpu_pkg::ALU_ADD:  return a + b;
            cpu_pkg::ALU_SUB:  return a - b;
            cpu_pkg::ALU_SLL:  return a << shamt;
            cpu_pkg::ALU_SLT:  return {{(cpu_pkg::XLEN - 1){1'b0}}, $signed(a) < $signed(b)};
            cpu_pkg::ALU_SLTU: return {{(cpu_pkg::XLEN - 1){1'b0}}, a < b};
            cpu_pkg::ALU_XOR:  return a ^ b;
            cpu_pkg::ALU_SRL:  return a >> shamt;
            cpu_pkg::ALU_SRA:  return $signed(a) >>> shamt;
            cpu_pkg::ALU_OR:   return a | b;
            cpu_pkg::ALU_AND:  return a & b;
            default:           return '0;
        endcase
    endfunction

    assign full = ent[cpu_pkg::RS_DEPTH - 1].valid;

    always_comb begin
        wk[cpu_pkg::RS_DEPTH] = '0;
        for (int i = 0; i < cpu_pkg::RS_DEPTH; i++) begin
            wk[i] = ent[i];
            // woken operands are captured at the edge
            if (result.valid && !ent[i].src_a.ready && ent[i].src_a.tag == result.tag) begin
                wk[i].src_a.ready = 1'b1;
                wk[i].src_a.value = result.value;
            end
            if (result.valid && !ent[i].src_b.ready && ent[i].src_b.tag == result.tag) begin
                wk[i].src_b.ready = 1'b1;
                wk[i].src_b.value = result.value;
            end
        end

        issue_hit = 1'b0;
        issue_idx = '0;
        for (int i = cpu_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (ent[i].valid && ent[i].src_a.ready && ent[i].src_b.ready) begin
                issue_hit = 1'b1;
                issue_idx = i[cpu_pkg::RS_IDX_W-1:0]; // lowest slot wins
            end
        end

        for (int i = 0; i < cpu_pkg::RS_DEPTH; i++) begin
            if (issue_hit && i >= int'(issue_idx)) begin
                nxt[i] = wk[i + 1]; // close the gap
            end else begin
                nxt[i] = wk[i];
            end
        end

        placed = 1'b0;
        for (int i = 0; i < cpu_pkg::RS_DEPTH; i++) begin
            if (accept && !placed && !nxt[i].valid) begin
                nxt[i] = dispatch;
                placed = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < cpu_pkg::RS_DEPTH; i++) begin
                ent[i].valid <= 1'b0;
            end
            result.valid <= 1'b0;
        end else begin
            ent          <= nxt;
            result.valid <= issue_hit;
            result.tag   <= ent[issue_idx].tag;
            result.value <= alu_calc(ent[issue_idx].op, ent[issue_idx].src_a.value,
                                     ent[issue_idx].src_b.value);
        end
    end

endmodule

// ==== arch_regfile.sv ====
module arch_regfile (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [cpu_pkg::LREG_W-1:0] rs1,
    input  logic [cpu_pkg::LREG_W-1:0] rs2,
    output logic [cpu_pkg::XLEN-1:0]   arch_a,
    output logic [cpu_pkg::XLEN-1:0]   arch_b,
    input  cpu_pkg::commit_t           commit
);

    // x0 has no storage
    logic [cpu_pkg::XLEN-1:0] regs [1:cpu_pkg::NUM_LREGS-1];

    assign arch_a = (rs1 == '0) ? '0 : regs[rs1];
    assign arch_b = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < cpu_pkg::NUM_LREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.value; // writes to x0 dropped here
        end
    end

endmodule

// ==== cpu_core.f ====
cpu_pkg.sv
inst_decode.sv
rename_table.sv
alu_station.sv
reorder_buffer.sv
arch_regfile.sv
cpu_core.sv
cpu_core_chk.sv
tb_cpu_core.sv

// ==== cpu_core.sv ====
module cpu_core (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                inst_valid,
    input  cpu_pkg::inst_word_u inst,
    output logic                dispatch_full,
    output cpu_pkg::commit_t    commit
);

    cpu_pkg::dispatch_t         dec_dispatch;
    cpu_pkg::dispatch_t         ren_dispatch;
    cpu_pkg::result_t           result;
    logic [cpu_pkg::LREG_W-1:0] rs1;
    logic [cpu_pkg::LREG_W-1:0] rs2;
    logic [cpu_pkg::XLEN-1:0]   arch_a;
    logic [cpu_pkg::XLEN-1:0]   arch_b;
    logic [cpu_pkg::TAG_W-1:0]  alloc_tag;
    logic [cpu_pkg::TAG_W-1:0]  commit_tag;
    logic [cpu_pkg::TAG_W-1:0]  lookup_tag_a;
    logic [cpu_pkg::TAG_W-1:0]  lookup_tag_b;
    logic                       rob_done_a;
    logic                       rob_done_b;
    logic [cpu_pkg::XLEN-1:0]   rob_value_a;
    logic [cpu_pkg::XLEN-1:0]   rob_value_b;
    logic                       rob_full;
    logic                       rs_full;
    logic                       accept;

    assign dispatch_full = rob_full | rs_full;
    assign accept        = dec_dispatch.valid & ~dispatch_full;

    inst_decode inst_decode_i (
        .inst_valid (inst_valid),
        .inst       (inst),
        .dispatch   (dec_dispatch),
        .rs1        (rs1),
        .rs2        (rs2)
    );

    rename_table rename_table_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .accept       (accept),
        .dispatch_in  (dec_dispatch),
        .rs1          (rs1),
        .rs2          (rs2),
        .alloc_tag    (alloc_tag),
        .arch_a       (arch_a),
        .arch_b       (arch_b),
        .lookup_tag_a (lookup_tag_a),
        .lookup_tag_b (lookup_tag_b),
        .rob_done_a   (rob_done_a),
        .rob_value_a  (rob_value_a),
        .rob_done_b   (rob_done_b),
        .rob_value_b  (rob_value_b),
        .result       (result),
        .commit       (commit),
        .commit_tag   (commit_tag),
        .dispatch_out (ren_dispatch)
    );

    alu_station alu_station_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .accept   (accept),
        .dispatch (ren_dispatch),
        .result   (result),
        .full     (rs_full)
    );

    reorder_buffer reorder_buffer_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .accept       (accept),
        .rd           (dec_dispatch.rd),
        .lookup_tag_a (lookup_tag_a),
        .lookup_tag_b (lookup_tag_b),
        .rob_done_a   (rob_done_a),
        .rob_value_a  (rob_value_a),
        .rob_done_b   (rob_done_b),
        .rob_value_b  (rob_value_b),
        .result       (result),
        .alloc_tag    (alloc_tag),
        .full         (rob_full),
        .commit       (commit),
        .commit_tag   (commit_tag)
    );

    arch_regfile arch_regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .arch_a (arch_a),
        .arch_b (arch_b),
        .commit (commit)
    );

endmodule

// ==== cpu_core_chk.sv ====
module cpu_core_chk (
    input logic                      clk,
    input logic                      arst_n,
    input logic [cpu_pkg::TAG_W:0]   count,
    input logic                      full,
    input logic                      accept,
    input logic [cpu_pkg::TAG_W-1:0] commit_tag,
    input cpu_pkg::result_t          result,
    input cpu_pkg::commit_t          commit
);

    // tags whose result went out and that have not retired yet
    logic [cpu_pkg::ROB_DEPTH-1:0] finished;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            finished <= '0;
        end else begin
            if (commit.valid) begin
                finished[commit_tag] <= 1'b0;
            end
            if (result.valid) begin
                finished[result.tag] <= 1'b1;
            end
        end
    end

    count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        count <= (cpu_pkg::TAG_W + 1)'(cpu_pkg::ROB_DEPTH))
        else $error("reorder buffer count above depth");

    // retirement only from a finished head
    commit_done: assert property (@(posedge clk) disable iff (!arst_n)
        commit.valid |-> finished[commit_tag])
        else $error("commit of an unfinished head entry");

    no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n)
        full |-> !accept)
        else $error("allocation into a full reorder buffer");

endmodule

bind reorder_buffer cpu_core_chk cpu_core_chk_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .count      (count),
    .full       (full),
    .accept     (accept),
    .commit_tag (commit_tag),
    .result     (result),
    .commit     (commit)
);

// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_LREGS = 32;
    localparam int LREG_W    = 5;
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W     = 3;
    localparam int RS_DEPTH  = 4;
    localparam int RS_IDX_W  = 2;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // sub / sra / srai

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [LREG_W-1:0] rs2;
        logic [LREG_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [LREG_W-1:0] rd;
        logic [6:0]        opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0]       imm12;
        logic [LREG_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [LREG_W-1:0] rd;
        logic [6:0]        opcode;
    } i_view_t;

    // same word, two field layouts
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } inst_word_u;

    typedef struct packed {
        logic             ready;
        logic [TAG_W-1:0] tag;   // producer tag while not ready
        logic [XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        logic              valid;
        alu_op_e           op;
        logic [LREG_W-1:0] rd;
        operand_t          src_a;
        operand_t          src_b;
        logic [TAG_W-1:0]  tag;
    } dispatch_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } result_t;

    typedef struct packed {
        logic              valid;
        logic [LREG_W-1:0] rd;
        logic [XLEN-1:0]   value;
    } commit_t;

endpackage

// ==== inst_decode.sv ====
module inst_decode (
    input  logic                       inst_valid,
    input  cpu_pkg::inst_word_u        inst,
    output cpu_pkg::dispatch_t         dispatch,
    output logic [cpu_pkg::LREG_W-1:0] rs1,
    output logic [cpu_pkg::LREG_W-1:0] rs2
);

    logic legal;

    // alt selects sub / sra
    function automatic cpu_pkg::alu_op_e map_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  return cpu_pkg::ALU_SLL;
            3'b010:  return cpu_pkg::ALU_SLT;
            3'b011:  return cpu_pkg::ALU_SLTU;
            3'b100:  return cpu_pkg::ALU_XOR;
            3'b101:  return alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  return cpu_pkg::ALU_OR;
            default: return cpu_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        dispatch = '0;
        legal    = 1'b0;
        rs1      = inst.r_view.rs1; // rs1 sits in the same place in both views
        rs2      = '0;
        case (inst.r_view.opcode)
            cpu_pkg::OPC_OP: begin
                rs2 = inst.r_view.rs2;
                legal = (inst.r_view.funct7 == '0) ||
                        (inst.r_view.funct7 == cpu_pkg::F7_ALT &&
                         (inst.r_view.funct3 == 3'b000 || inst.r_view.funct3 == 3'b101));
                dispatch.op = map_op(inst.r_view.funct3, inst.r_view.funct7[5]);
                dispatch.rd = inst.r_view.rd;
            end
            cpu_pkg::OPC_OP_IMM: begin
                case (inst.i_view.funct3)
                    3'b001:  legal = (inst.i_view.imm12[11:5] == '0);
                    3'b101:  legal = (inst.i_view.imm12[11:5] == '0) ||
                                     (inst.i_view.imm12[11:5] == cpu_pkg::F7_ALT);
                    default: legal = 1'b1;
                endcase
                dispatch.op = map_op(inst.i_view.funct3,
                                     inst.i_view.funct3 == 3'b101 && inst.i_view.imm12[10]);
                dispatch.rd = inst.i_view.rd;
                // immediate is already resolved
                dispatch.src_b.ready = 1'b1;
                dispatch.src_b.value = {{(cpu_pkg::XLEN - 12){inst.i_view.imm12[11]}},
                                        inst.i_view.imm12};
            end
            default: ;
        endcase
        dispatch.valid = inst_valid & legal;
    end

endmodule

// ==== rename_table.sv ====
module rename_table (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       accept,
    input  cpu_pkg::dispatch_t         dispatch_in,
    input  logic [cpu_pkg::LREG_W-1:0] rs1,
    input  logic [cpu_pkg::LREG_W-1:0] rs2,
    input  logic [cpu_pkg::TAG_W-1:0]  alloc_tag,
    input  logic [cpu_pkg::XLEN-1:0]   arch_a,
    input  logic [cpu_pkg::XLEN-1:0]   arch_b,
    output logic [cpu_pkg::TAG_W-1:0]  lookup_tag_a,
    output logic [cpu_pkg::TAG_W-1:0]  lookup_tag_b,
    input  logic                       rob_done_a,
    input  logic [cpu_pkg::XLEN-1:0]   rob_value_a,
    input  logic                       rob_done_b,
    input  logic [cpu_pkg::XLEN-1:0]   rob_value_b,
    input  cpu_pkg::result_t           result,
    input  cpu_pkg::commit_t           commit,
    input  logic [cpu_pkg::TAG_W-1:0]  commit_tag,
    output cpu_pkg::dispatch_t         dispatch_out
);

    logic [cpu_pkg::NUM_LREGS-1:0] busy;
    logic [cpu_pkg::TAG_W-1:0]     tag_map [cpu_pkg::NUM_LREGS];

    function automatic cpu_pkg::operand_t resolve(
        input logic                      busy_bit,
        input logic [cpu_pkg::TAG_W-1:0] map_tag,
        input logic [cpu_pkg::XLEN-1:0]  arch_val,
        input logic                      rob_done,
        input logic [cpu_pkg::XLEN-1:0]  rob_val,
        input cpu_pkg::result_t          res
    );
        cpu_pkg::operand_t opnd;
        opnd.tag   = map_tag;
        opnd.ready = 1'b1;
        if (!busy_bit) begin
            opnd.value = arch_val;
        end else if (rob_done) begin
            opnd.value = rob_val;
        end else if (res.valid && res.tag == map_tag) begin
            opnd.value = res.value; // result landing this cycle
        end else begin
            opnd.ready = 1'b0;
            opnd.value = '0;
        end
        return opnd;
    endfunction

    assign lookup_tag_a = tag_map[rs1];
    assign lookup_tag_b = tag_map[rs2];

    always_comb begin
        dispatch_out       = dispatch_in;
        dispatch_out.tag   = alloc_tag;
        dispatch_out.src_a = resolve(busy[rs1], tag_map[rs1], arch_a,
                                     rob_done_a, rob_value_a, result);
        if (!dispatch_in.src_b.ready) begin
            dispatch_out.src_b = resolve(busy[rs2], tag_map[rs2], arch_b,
                                         rob_done_b, rob_value_b, result);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            // clear only if no younger writer took the register
            if (commit.valid && busy[commit.rd] && tag_map[commit.rd] == commit_tag) begin
                busy[commit.rd] <= 1'b0;
            end
            if (accept && dispatch_in.rd != '0) begin
                busy[dispatch_in.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && dispatch_in.rd != '0) begin
            tag_map[dispatch_in.rd] <= alloc_tag;
        end
    end

endmodule

// ==== reorder_buffer.sv ====
module reorder_buffer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       accept,
    input  logic [cpu_pkg::LREG_W-1:0] rd,
    input  logic [cpu_pkg::TAG_W-1:0]  lookup_tag_a,
    input  logic [cpu_pkg::TAG_W-1:0]  lookup_tag_b,
    output logic                       rob_done_a,
    output logic [cpu_pkg::XLEN-1:0]   rob_value_a,
    output logic                       rob_done_b,
    output logic [cpu_pkg::XLEN-1:0]   rob_value_b,
    input  cpu_pkg::result_t           result,
    output logic [cpu_pkg::TAG_W-1:0]  alloc_tag,
    output logic                       full,
    output cpu_pkg::commit_t           commit,
    output logic [cpu_pkg::TAG_W-1:0]  commit_tag
);

    logic [cpu_pkg::TAG_W-1:0]  head;
    logic [cpu_pkg::TAG_W-1:0]  tail;
    logic [cpu_pkg::TAG_W:0]    count;
    logic                       done    [cpu_pkg::ROB_DEPTH];
    logic [cpu_pkg::LREG_W-1:0] rd_q    [cpu_pkg::ROB_DEPTH];
    logic [cpu_pkg::XLEN-1:0]   value_q [cpu_pkg::ROB_DEPTH];
    logic                       retire;

    assign alloc_tag  = tail;
    assign commit_tag = head;
    assign full       = (count == (cpu_pkg::TAG_W + 1)'(cpu_pkg::ROB_DEPTH));
    assign retire     = (count != '0) && done[head];

    // operand lookups for rename
    assign rob_done_a  = done[lookup_tag_a];
    assign rob_value_a = value_q[lookup_tag_a];
    assign rob_done_b  = done[lookup_tag_b];
    assign rob_value_b = value_q[lookup_tag_b];

    always_comb begin
        commit.valid = retire;
        commit.rd    = rd_q[head];
        commit.value = value_q[head];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < cpu_pkg::ROB_DEPTH; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (accept) begin
                tail       <= tail + 1'b1; // wraps with the power-of-two depth
                done[tail] <= 1'b0;
            end
            if (result.valid) begin
                done[result.tag] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({accept, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q[tail] <= rd;
        end
        if (result.valid) begin
            value_q[result.tag] <= result.value;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_cpu_core -f cpu_core.f \
    -o sim_cpu_core > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_cpu_core > sim.log 2>&1
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_cpu_core.sv ====
module tb_cpu_core;

    logic                clk;
    logic                arst_n;
    logic                inst_valid;
    cpu_pkg::inst_word_u inst;
    logic                dispatch_full;
    cpu_pkg::commit_t    commit;

    logic [cpu_pkg::XLEN-1:0] ref_regs [cpu_pkg::NUM_LREGS];
    cpu_pkg::commit_t         exp_q [$];
    int errors = 0;
    int checks = 0;
    int wait_limit = 400;
    logic saw_full;

    cpu_core cpu_core_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .dispatch_full (dispatch_full),
        .commit        (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_commit(input cpu_pkg::commit_t got, input cpu_pkg::commit_t exp,
                                input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got rd=%0d value=%h, expected rd=%0d value=%h",
                     $time, name, got.rd, got.value, exp.rd, exp.value);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $finish;
    endtask

    // independent RV32I semantics
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // caller sits 1 unit after a rising edge
    task automatic present(input logic [31:0] word);
        int n;
        n = 0;
        while (dispatch_full) begin
            saw_full   = 1'b1;
            inst_valid = 1'b0;
            n++;
            if (n > wait_limit) abort_on_timeout("dispatch_full to drop");
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b1;
        inst       = word;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic expect_commit(input logic [4:0] rd, input logic [31:0] val);
        cpu_pkg::commit_t exp;
        exp.valid = 1'b1;
        exp.rd    = rd;
        exp.value = val;
        exp_q.push_back(exp);
        if (rd != 5'd0) ref_regs[rd] = val;
    endtask

    task automatic issue_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
        logic [31:0] val;
        val = alu_model(f3, f3 == 3'd5 && imm[10], ref_regs[rs1], {{20{imm[11]}}, imm});
        expect_commit(rd, val);
        present({imm, rs1, f3, rd, cpu_pkg::OPC_OP_IMM});
    endtask

    task automatic issue_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] val;
        val = alu_model(f3, f7[5], ref_regs[rs1], ref_regs[rs2]);
        expect_commit(rd, val);
        present({f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP});
    endtask

    task automatic drain(input string name);
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            n++;
            if (n > wait_limit) abort_on_timeout("outstanding commits");
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk); // quiet window for stray commits
        #1;
        $display("test %s finished, errors so far %0d", name, errors);
    endtask

    function automatic logic [4:0] rand_reg();
        return 5'(1 + ($urandom() % 31));
    endfunction

    // in-order commit checker
    always @(negedge clk) begin
        cpu_pkg::commit_t exp;
        if (arst_n && commit.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a commit appeared at %0t with nothing outstanding", $time);
            end else begin
                exp = exp_q.pop_front();
                check_commit(commit, exp, "commit");
            end
        end
    end

    task automatic test_reset();
        repeat (3) begin
            @(posedge clk);
            #1;
            check_level(commit.valid, 1'b0, "commit.valid");
            check_level(dispatch_full, 1'b0, "dispatch_full");
        end
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        check_level(commit.valid, 1'b0, "commit.valid");
        check_level(dispatch_full, 1'b0, "dispatch_full");
        $display("test reset finished, errors so far %0d", errors);
    endtask

    task automatic test_imm_ops();
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5) begin
                issue_i(3'(f), rand_reg(), rand_reg(), {7'b0, 5'($urandom())});
            end else begin
                issue_i(3'(f), rand_reg(), rand_reg(), 12'($urandom()));
            end
        end
        issue_i(3'd5, rand_reg(), rand_reg(), {7'b0100000, 5'($urandom())}); // srai
        drain("immediate_ops");
    endtask

    task automatic test_chain();
        issue_i(3'd0, 5'd5, 5'd0, 12'($urandom()));
        for (int i = 0; i < 6; i++) begin
            issue_i(3'd0, 5'd5, 5'd5, 12'($urandom()));
            issue_i(3'd4, 5'd6, 5'd5, 12'($urandom()));
            issue_r(7'b0, 3'd0, 5'd5, 5'd5, 5'd6);
        end
        drain("dependency_chain");
    endtask

    task automatic test_reg_ops();
        for (int r = 1; r <= 4; r++) begin
            issue_i(3'd0, 5'(r), 5'd0, 12'($urandom()));
            issue_i(3'd1, 5'(r), 5'(r), {7'b0, 5'($urandom())});
            issue_i(3'd6, 5'(r), 5'(r), 12'($urandom()));
        end
        for (int f = 0; f < 8; f++) begin
            issue_r(7'b0, 3'(f), rand_reg(), 5'(1 + $urandom() % 4), 5'(1 + $urandom() % 4));
        end
        issue_r(7'b0100000, 3'd0, rand_reg(), 5'd1, 5'd2); // sub
        issue_r(7'b0100000, 3'd5, rand_reg(), 5'd3, 5'd4); // sra
        drain("register_ops");
    endtask

    task automatic test_backpressure();
        saw_full = 1'b0;
        for (int i = 0; i < 20; i++) begin
            issue_i(3'd0, 5'd7, 5'd7, 12'($urandom()));
        end
        check_level(saw_full, 1'b1, "dispatch_full seen");
        drain("backpressure");
    endtask

    task automatic test_x0_illegal();
        issue_i(3'd0, 5'd0, 5'd1, 12'h005);
        issue_r(7'b0, 3'd0, 5'd8, 5'd0, 5'd0);
        issue_i(3'd0, 5'd9, 5'd0, 12'h000);
        present({12'h123, 5'd1, 3'd0, 5'd10, 7'b0000011}); // load opcode
        present({7'b1000000, 5'd1, 5'd2, 3'd0, 5'd11, cpu_pkg::OPC_OP}); // bad funct7
        drain("x0_and_illegal");
    endtask

    initial begin
        void'($urandom(43131));
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        saw_full   = 1'b0;
        for (int i = 0; i < cpu_pkg::NUM_LREGS; i++) ref_regs[i] = '0;
        test_reset();
        test_imm_ops();
        test_chain();
        test_reg_ops();
        test_backpressure();
        test_x0_illegal();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
